/* design/wiscPkg.sv */
// WISC core shared types
`default_nettype none

package wiscPkg;

	typedef logic [15:0] word_t;
	typedef logic [15:0] instr_t;
	typedef logic [2:0] regAddr_t;
	typedef logic [4:0] opcode_t;
	typedef logic [3:0] aluOp_t;

	localparam int defaultDataMemWords = 256;

	localparam opcode_t opHalt = 5'b00000;
	localparam opcode_t opNop = 5'b00001;
	localparam opcode_t opJ = 5'b00100;
	localparam opcode_t opJr = 5'b00101;
	localparam opcode_t opJal = 5'b00110;
	localparam opcode_t opJalr = 5'b00111;
	localparam opcode_t opAddi = 5'b01000;
	localparam opcode_t opSubi = 5'b01001;
	localparam opcode_t opXori = 5'b01010;
	localparam opcode_t opAndni = 5'b01011;
	localparam opcode_t opBeqz = 5'b01100;
	localparam opcode_t opBnez = 5'b01101;
	localparam opcode_t opBltz = 5'b01110;
	localparam opcode_t opBgez = 5'b01111;
	localparam opcode_t opSt = 5'b10000;
	localparam opcode_t opLd = 5'b10001;
	localparam opcode_t opSlbi = 5'b10010;
	localparam opcode_t opStu = 5'b10011;
	localparam opcode_t opRoli = 5'b10100;
	localparam opcode_t opSlli = 5'b10101;
	localparam opcode_t opRori = 5'b10110;
	localparam opcode_t opSrli = 5'b10111;
	localparam opcode_t opLbi = 5'b11000;
	localparam opcode_t opBtr = 5'b11001;
	localparam opcode_t opShift = 5'b11010;
	localparam opcode_t opArith = 5'b11011;
	localparam opcode_t opSeq = 5'b11100;
	localparam opcode_t opSlt = 5'b11101;
	localparam opcode_t opSle = 5'b11110;
	localparam opcode_t opSco = 5'b11111;

	// Low two bits follow the function field of the R-format groups
	localparam aluOp_t aluAdd = 4'd0;
	localparam aluOp_t aluSub = 4'd1;
	localparam aluOp_t aluXor = 4'd2;
	localparam aluOp_t aluAndn = 4'd3;
	localparam aluOp_t aluRol = 4'd4;
	localparam aluOp_t aluSll = 4'd5;
	localparam aluOp_t aluRor = 4'd6;
	localparam aluOp_t aluSrl = 4'd7;
	localparam aluOp_t aluSeq = 4'd8;
	localparam aluOp_t aluSlt = 4'd9;
	localparam aluOp_t aluSle = 4'd10;
	localparam aluOp_t aluSco = 4'd11;
	localparam aluOp_t aluBtr = 4'd12;
	localparam aluOp_t aluPassB = 4'd13;

endpackage

`default_nettype wire

/* design/fetchUnit.sv */
// Program counter and halt latch
`timescale 1ns/1ns
`default_nettype none

module fetchUnit
	import wiscPkg::*;
(
	input logic clk,
	input logic reset,
	input logic halt,
	input logic branchCtl,
	input logic branchTaken,
	input logic jumpCtl,
	input word_t jumpTarget,
	output word_t pc,
	output word_t nextPcSeq,
	output logic halted
);

	logic redirect;

	// Byte addressed, one instruction is two bytes
	assign nextPcSeq = pc + 16'd2;
	assign redirect = (branchCtl && branchTaken) || jumpCtl;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			halted <= 1'b0;
		end else begin
			if (halt) begin
				halted <= 1'b1;
			end
			// PC stays on the halt instruction
			if (!halt && !halted) begin
				pc <= redirect ? jumpTarget : nextPcSeq;
			end
		end
	end

	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
		else $error("fetchUnit: odd pc %h", pc);

endmodule

`default_nettype wire

/* design/control.sv */
// Instruction decoder
`timescale 1ns/1ns
`default_nettype none

module control
	import wiscPkg::*;
(
	input instr_t instr,
	output logic regWrite,
	output logic aluSrc,
	output logic memWrite,
	output logic memRead,
	output logic memToReg,
	output logic branchCtl,
	output logic jumpCtl,
	output logic immCtl,
	output logic stu,
	output logic slbi,
	output logic lbi,
	output logic link,
	output logic halt,
	output aluOp_t aluOp
);

	opcode_t opcode;
	logic supported;

	assign opcode = instr[15:11];

	always_comb begin
		regWrite = 1'b0;
		aluSrc = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		memToReg = 1'b0;
		branchCtl = 1'b0;
		jumpCtl = 1'b0;
		immCtl = 1'b0;
		stu = 1'b0;
		slbi = 1'b0;
		lbi = 1'b0;
		link = 1'b0;
		halt = 1'b0;
		aluOp = aluAdd;
		supported = 1'b1;
		case (opcode)
			opHalt: halt = 1'b1;
			opNop: supported = 1'b1;
			opAddi, opSubi, opXori, opAndni: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				// Only addi and subi take a signed immediate
				immCtl = !opcode[1];
				aluOp = {2'b00, opcode[1:0]};
			end
			opRoli, opSlli, opRori, opSrli: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = {2'b01, opcode[1:0]};
			end
			opSt, opLd, opStu: begin
				aluSrc = 1'b1;
				immCtl = 1'b1;
				memWrite = (opcode != opLd);
				memRead = (opcode == opLd);
				memToReg = (opcode == opLd);
				regWrite = (opcode != opSt);
				stu = (opcode == opStu);
			end
			opLbi: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				immCtl = 1'b1;
				lbi = 1'b1;
				aluOp = aluPassB;
			end
			opSlbi: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				slbi = 1'b1;
			end
			opBtr: begin
				regWrite = 1'b1;
				aluOp = aluBtr;
			end
			opArith: begin
				regWrite = 1'b1;
				aluOp = {2'b00, instr[1:0]};
			end
			opShift: begin
				regWrite = 1'b1;
				aluOp = {2'b01, instr[1:0]};
			end
			opSeq, opSlt, opSle, opSco: begin
				regWrite = 1'b1;
				aluOp = {2'b10, opcode[1:0]};
			end
			opBeqz, opBnez, opBltz, opBgez: begin
				branchCtl = 1'b1;
				immCtl = 1'b1;
			end
			opJ, opJr, opJal, opJalr: begin
				jumpCtl = 1'b1;
				immCtl = 1'b1;
				regWrite = opcode[1];
				link = opcode[1];
			end
			// siic, rti and undefined opcodes fall through as nops
			default: supported = 1'b0;
		endcase
	end

	always_comb begin
		if (!$isunknown(instr)) begin
			assert (supported) else $error("control: unsupported opcode %b", opcode);
		end
	end

endmodule

`default_nettype wire

/* design/regFile.sv */
// Register file, eight by 16 bits
`timescale 1ns/1ns
`default_nettype none

module regFile
	import wiscPkg::*;
(
	input logic clk,
	input logic reset,
	input regAddr_t readAddrA,
	input regAddr_t readAddrB,
	input regAddr_t writeAddr,
	input logic writeEn,
	input word_t writeData,
	output word_t readDataA,
	output word_t readDataB
);

	word_t regs [8];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// No bypass, a write shows up on the next cycle
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

/* design/execUnit.sv */
// Immediate, ALU and branch logic
`timescale 1ns/1ns
`default_nettype none

module execUnit
	import wiscPkg::*;
(
	input instr_t instr,
	input word_t readDataA,
	input word_t readDataB,
	input word_t pc,
	input word_t nextPcSeq,
	input logic aluSrc,
	input logic immCtl,
	input logic lbi,
	input logic slbi,
	input logic branchCtl,
	input logic jumpCtl,
	input aluOp_t aluOp,
	output word_t aluResult,
	output word_t jumpTarget,
	output logic branchTaken
);

	logic imm8Sel;
	logic imm11Sel;
	logic regJump;
	logic [3:0] amt;
	logic [16:0] carrySum;
	word_t imm;
	word_t opB;
	word_t reversed;
	word_t aluOut;

	// jr and jalr have bit 11 set and an 8-bit immediate
	assign regJump = jumpCtl && instr[11];
	assign imm11Sel = jumpCtl && !instr[11];
	assign imm8Sel = lbi || slbi || branchCtl || regJump;

	always_comb begin
		if (imm11Sel) begin
			imm = immCtl ? {{5{instr[10]}}, instr[10:0]} : {5'b0, instr[10:0]};
		end else if (imm8Sel) begin
			imm = immCtl ? {{8{instr[7]}}, instr[7:0]} : {8'b0, instr[7:0]};
		end else begin
			imm = immCtl ? {{11{instr[4]}}, instr[4:0]} : {11'b0, instr[4:0]};
		end
	end

	assign opB = aluSrc ? imm : readDataB;
	assign amt = opB[3:0];
	assign carrySum = {1'b0, readDataA} + {1'b0, opB};

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			reversed[i] = readDataA[15 - i];
		end
	end

	always_comb begin
		case (aluOp)
			aluAdd: aluOut = carrySum[15:0];
			// Subtract is B minus A in this ISA
			aluSub: aluOut = opB - readDataA;
			aluXor: aluOut = readDataA ^ opB;
			aluAndn: aluOut = readDataA & ~opB;
			aluRol: aluOut = (readDataA << amt) | (readDataA >> (5'd16 - {1'b0, amt}));
			aluSll: aluOut = readDataA << amt;
			aluRor: aluOut = (readDataA >> amt) | (readDataA << (5'd16 - {1'b0, amt}));
			aluSrl: aluOut = readDataA >> amt;
			aluSeq: aluOut = {15'b0, readDataA == opB};
			aluSlt: aluOut = {15'b0, $signed(readDataA) < $signed(opB)};
			aluSle: aluOut = {15'b0, $signed(readDataA) <= $signed(opB)};
			aluSco: aluOut = {15'b0, carrySum[16]};
			aluBtr: aluOut = reversed;
			aluPassB: aluOut = opB;
			default: aluOut = carrySum[15:0];
		endcase
	end

	assign aluResult = slbi ? {readDataA[7:0], imm[7:0]} : aluOut;

	always_comb begin
		case (instr[12:11])
			2'b00: branchTaken = (readDataA == '0);
			2'b01: branchTaken = (readDataA != '0);
			2'b10: branchTaken = readDataA[15];
			default: branchTaken = !readDataA[15];
		endcase
	end

	assign jumpTarget = regJump ? readDataA + imm : nextPcSeq + imm;

endmodule

`default_nettype wire

/* design/memWriteback.sv */
// Data memory and write-back select
`timescale 1ns/1ns
`default_nettype none

module memWriteback
	import wiscPkg::*;
#(
	parameter int dataMemWords = defaultDataMemWords
) (
	input logic clk,
	input logic reset,
	input logic memWrite,
	input logic memRead,
	input logic memToReg,
	input logic regWrite,
	input logic stu,
	input logic link,
	input logic halted,
	input word_t aluResult,
	input word_t storeData,
	input word_t nextPcSeq,
	input instr_t instr,
	output logic wbEnable,
	output regAddr_t wbReg,
	output word_t wbData
);

	localparam int addrBits = $clog2(dataMemWords);

	word_t dataMem [dataMemWords];
	logic [addrBits-1:0] memIndex;
	opcode_t opcode;
	word_t loadData;

	assign opcode = instr[15:11];
	// Word index, bit 0 of the byte address is dropped
	assign memIndex = aluResult[addrBits:1];

	always_ff @(posedge clk) begin
		if (memWrite && !halted && !reset) begin
			dataMem[memIndex] <= storeData;
		end
	end

	assign loadData = memRead ? dataMem[memIndex] : '0;

	always_comb begin
		if (link) begin
			wbReg = 3'd7;
		end else if (stu || opcode == opLbi || opcode == opSlbi) begin
			wbReg = instr[10:8];
		end else if (opcode[4:3] == 2'b11) begin
			// R-format destination
			wbReg = instr[4:2];
		end else begin
			wbReg = instr[7:5];
		end
	end

	assign wbEnable = regWrite && !halted && !reset;
	assign wbData = memToReg ? loadData : (link ? nextPcSeq : aluResult);

	memInRange: assert property (@(posedge clk) disable iff (reset)
		(memRead || memWrite) && !halted |-> (aluResult >> 1) < dataMemWords)
		else $error("memWriteback: address %h outside data memory", aluResult);

endmodule

`default_nettype wire

/* design/wiscCore.sv */
// Single-cycle WISC core
`timescale 1ns/1ns
`default_nettype none

module wiscCore
	import wiscPkg::*;
#(
	parameter int dataMemWords = defaultDataMemWords
) (
	input logic clk,
	input logic reset,
	output word_t pc,
	input instr_t instr,
	output logic wbEnable,
	output regAddr_t wbReg,
	output word_t wbData,
	output logic memWriteEn,
	output word_t memAddr,
	output word_t memWriteData,
	output logic halted
);

	logic regWrite;
	logic aluSrc;
	logic memWrite;
	logic memRead;
	logic memToReg;
	logic branchCtl;
	logic jumpCtl;
	logic immCtl;
	logic stu;
	logic slbi;
	logic lbi;
	logic link;
	logic halt;
	logic branchTaken;
	aluOp_t aluOp;
	word_t nextPcSeq;
	word_t jumpTarget;
	word_t readDataA;
	word_t readDataB;
	word_t aluResult;

	fetchUnit i_fetchUnit (
		.clk(clk),
		.reset(reset),
		.halt(halt),
		.branchCtl(branchCtl),
		.branchTaken(branchTaken),
		.jumpCtl(jumpCtl),
		.jumpTarget(jumpTarget),
		.pc(pc),
		.nextPcSeq(nextPcSeq),
		.halted(halted)
	);

	control i_control (
		.instr(instr),
		.regWrite(regWrite),
		.aluSrc(aluSrc),
		.memWrite(memWrite),
		.memRead(memRead),
		.memToReg(memToReg),
		.branchCtl(branchCtl),
		.jumpCtl(jumpCtl),
		.immCtl(immCtl),
		.stu(stu),
		.slbi(slbi),
		.lbi(lbi),
		.link(link),
		.halt(halt),
		.aluOp(aluOp)
	);

	// Port B reads Rt, or the store data register for st and stu
	regFile i_regFile (
		.clk(clk),
		.reset(reset),
		.readAddrA(instr[10:8]),
		.readAddrB(instr[7:5]),
		.writeAddr(wbReg),
		.writeEn(wbEnable),
		.writeData(wbData),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	execUnit i_execUnit (
		.instr(instr),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.pc(pc),
		.nextPcSeq(nextPcSeq),
		.aluSrc(aluSrc),
		.immCtl(immCtl),
		.lbi(lbi),
		.slbi(slbi),
		.branchCtl(branchCtl),
		.jumpCtl(jumpCtl),
		.aluOp(aluOp),
		.aluResult(aluResult),
		.jumpTarget(jumpTarget),
		.branchTaken(branchTaken)
	);

	memWriteback #(
		.dataMemWords(dataMemWords)
	) i_memWriteback (
		.clk(clk),
		.reset(reset),
		.memWrite(memWrite),
		.memRead(memRead),
		.memToReg(memToReg),
		.regWrite(regWrite),
		.stu(stu),
		.link(link),
		.halted(halted),
		.aluResult(aluResult),
		.storeData(readDataB),
		.nextPcSeq(nextPcSeq),
		.instr(instr),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	// Trace of the store committed at the next edge
	assign memWriteEn = memWrite && !halted && !reset;
	assign memAddr = aluResult;
	assign memWriteData = readDataB;

endmodule

`default_nettype wire

/* tb/wiscPrograms.svh */
// WISC test programs
`ifndef WISC_PROGRAMS_SVH
`define WISC_PROGRAMS_SVH

localparam int numPrograms = 6;
localparam int totalWords = 87;
localparam int progStart [numPrograms] = '{0, 10, 29, 45, 55, 83};
localparam int progLen [numPrograms] = '{10, 19, 16, 10, 28, 4};
// lbi and slbi bytes get random values in the first two programs
localparam bit randomOps [numPrograms] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

localparam instr_t progWords [totalWords] = '{
	// Immediate arithmetic
	{opLbi, 3'd1, 8'h00}, {opSlbi, 3'd1, 8'h00}, {opLbi, 3'd2, 8'h00},
	{opLbi, 3'd3, 8'h00}, {opAddi, 3'd1, 3'd4, 5'h13}, {opSubi, 3'd1, 3'd5, 5'h07},
	{opXori, 3'd2, 3'd6, 5'h1f}, {opAndni, 3'd1, 3'd7, 5'h15},
	{opAddi, 3'd3, 3'd4, 5'h0f}, {opHalt, 11'd0},
	// Register forms
	{opLbi, 3'd1, 8'h00}, {opSlbi, 3'd1, 8'h00}, {opLbi, 3'd2, 8'h00},
	{opSlbi, 3'd2, 8'h00}, {opLbi, 3'd3, 8'h00},
	{opArith, 3'd1, 3'd2, 3'd4, 2'd0}, {opArith, 3'd1, 3'd2, 3'd5, 2'd1},
	{opArith, 3'd1, 3'd2, 3'd6, 2'd2}, {opArith, 3'd1, 3'd2, 3'd7, 2'd3},
	{opShift, 3'd1, 3'd3, 3'd4, 2'd0}, {opShift, 3'd1, 3'd3, 3'd5, 2'd1},
	{opShift, 3'd1, 3'd3, 3'd6, 2'd2}, {opShift, 3'd1, 3'd3, 3'd7, 2'd3},
	{opRoli, 3'd1, 3'd4, 5'h05}, {opSlli, 3'd1, 3'd5, 5'h0c},
	{opRori, 3'd1, 3'd6, 5'h10}, {opSrli, 3'd1, 3'd7, 5'h01},
	{opBtr, 3'd2, 3'd0, 3'd3, 2'd0}, {opHalt, 11'd0},
	// Set instructions on extremes
	{opLbi, 3'd1, 8'h80}, {opSlbi, 3'd1, 8'h00}, {opLbi, 3'd2, 8'h7f},
	{opSlbi, 3'd2, 8'hff}, {opLbi, 3'd3, 8'hff}, {opLbi, 3'd4, 8'h01},
	{opSeq, 3'd1, 3'd1, 3'd5, 2'd0}, {opSeq, 3'd1, 3'd2, 3'd5, 2'd0},
	{opSlt, 3'd1, 3'd2, 3'd6, 2'd0}, {opSlt, 3'd2, 3'd1, 3'd6, 2'd0},
	{opSle, 3'd1, 3'd1, 3'd7, 2'd0}, {opSle, 3'd2, 3'd1, 3'd7, 2'd0},
	{opSco, 3'd3, 3'd4, 3'd5, 2'd0}, {opSco, 3'd4, 3'd4, 3'd5, 2'd0},
	{opSco, 3'd1, 3'd1, 3'd5, 2'd0}, {opHalt, 11'd0},
	// Memory
	{opLbi, 3'd1, 8'h10}, {opLbi, 3'd2, 8'h5a}, {opSlbi, 3'd2, 8'hc3},
	{opSt, 3'd1, 3'd2, 5'h02}, {opLd, 3'd1, 3'd3, 5'h02}, {opStu, 3'd1, 3'd3, 5'h1e},
	{opLd, 3'd1, 3'd4, 5'h00}, {opSt, 3'd1, 3'd1, 5'h04}, {opLd, 3'd1, 3'd5, 5'h04},
	{opHalt, 11'd0},
	// Control flow, skipped slots hold halt or lbi r7
	{opLbi, 3'd1, 8'h00}, {opLbi, 3'd2, 8'hfd}, {opBeqz, 3'd1, 8'h02},
	{opLbi, 3'd7, 8'h11}, {opBnez, 3'd1, 8'h02}, {opBltz, 3'd2, 8'h02},
	{opLbi, 3'd7, 8'h22}, {opBgez, 3'd2, 8'h02}, {opBgez, 3'd1, 8'h02},
	{opHalt, 11'd0}, {opBnez, 3'd2, 8'h02}, {opHalt, 11'd0},
	{opBeqz, 3'd2, 8'h02}, {opBltz, 3'd1, 8'h02}, {opJ, 11'h004},
	{opHalt, 11'd0}, {opHalt, 11'd0}, {opJal, 11'h002}, {opHalt, 11'd0},
	{opLbi, 3'd3, 8'h30}, {opJr, 3'd3, 8'h00}, {opHalt, 11'd0},
	{opHalt, 11'd0}, {opHalt, 11'd0}, {opJalr, 3'd3, 8'h04},
	{opHalt, 11'd0}, {opNop, 11'd0}, {opHalt, 11'd0},
	// Halt with a store and an add behind it
	{opLbi, 3'd1, 8'h04}, {opHalt, 11'd0}, {opSt, 3'd1, 3'd1, 5'h00},
	{opAddi, 3'd1, 3'd2, 5'h01}
};

`endif

/* tb/wiscCoreTb.sv */
// WISC core testbench
`timescale 1ns/1ns
`default_nettype none

module wiscCoreTb
	import wiscPkg::*;
;

	`include "wiscPrograms.svh"

	localparam int numRuns = numPrograms + 1;
	localparam int cycleLimit = totalWords * 2 + numRuns * 5 + 100;

	logic clk;
	logic reset;
	word_t pc;
	instr_t instr;
	logic wbEnable;
	regAddr_t wbReg;
	word_t wbData;
	logic memWriteEn;
	word_t memAddr;
	word_t memWriteData;
	logic halted;

	instr_t imem [256];
	word_t refRegs [8];
	word_t refMem [256];
	word_t refPc;
	logic refHalted;
	logic checking;
	logic done;
	int postCount;
	int postLimit;
	int testErrors;
	int passCount;
	int failCount;
	int cycleCount;
	integer seed;

	wiscCore #(
		.dataMemWords(256)
	) i_wiscCore (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.memWriteEn(memWriteEn),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.halted(halted)
	);

	always #4 clk = ~clk;

	// Instruction memory answers the pc on the falling edge
	always @(negedge clk) begin
		instr <= imem[pc[8:1]];
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout: run exceeded %0d cycles", cycleLimit);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic word_t rotateLeft(input word_t v, input logic [3:0] n);
		word_t r;
		r = v;
		for (int i = 0; i < n; i++) begin
			r = {r[14:0], r[15]};
		end
		return r;
	endfunction

	function automatic word_t rotateRight(input word_t v, input logic [3:0] n);
		word_t r;
		r = v;
		for (int i = 0; i < n; i++) begin
			r = {r[0], r[15:1]};
		end
		return r;
	endfunction

	function automatic word_t shiftOp(input logic [1:0] f, input word_t v, input logic [3:0] n);
		case (f)
			2'd0: return rotateLeft(v, n);
			2'd1: return v << n;
			2'd2: return rotateRight(v, n);
			default: return v >> n;
		endcase
	endfunction

	// One step of the instruction-set model at refPc
	function automatic void refStep(input instr_t ins, output logic en, output regAddr_t rd,
			output word_t data, output logic memEn, output word_t addr,
			output word_t stData, output word_t nextPc, output logic isHalt);
		opcode_t op;
		word_t a;
		word_t b;
		word_t s5;
		word_t z5;
		word_t s8;
		word_t s11;
		word_t seqPc;
		logic [16:0] wide;
		logic taken;
		op = ins[15:11];
		a = refRegs[ins[10:8]];
		b = refRegs[ins[7:5]];
		s5 = {{11{ins[4]}}, ins[4:0]};
		z5 = {11'd0, ins[4:0]};
		s8 = {{8{ins[7]}}, ins[7:0]};
		s11 = {{5{ins[10]}}, ins[10:0]};
		seqPc = refPc + 16'd2;
		wide = {1'b0, a} + {1'b0, b};
		en = 1'b0;
		rd = ins[7:5];
		data = '0;
		memEn = 1'b0;
		addr = a + s5;
		stData = b;
		nextPc = seqPc;
		isHalt = 1'b0;
		taken = 1'b0;
		case (op)
			opHalt: begin
				isHalt = 1'b1;
				nextPc = refPc;
			end
			opAddi: {en, data} = {1'b1, a + s5};
			opSubi: {en, data} = {1'b1, s5 - a};
			opXori: {en, data} = {1'b1, a ^ z5};
			opAndni: {en, data} = {1'b1, a & ~z5};
			opRoli, opSlli, opRori, opSrli: {en, data} = {1'b1, shiftOp(op[1:0], a, ins[3:0])};
			opSt: memEn = 1'b1;
			opLd: {en, data} = {1'b1, refMem[addr[8:1]]};
			opStu: begin
				memEn = 1'b1;
				{en, rd, data} = {1'b1, ins[10:8], addr};
			end
			opLbi: {en, rd, data} = {1'b1, ins[10:8], s8};
			opSlbi: {en, rd, data} = {1'b1, ins[10:8], a[7:0], ins[7:0]};
			opBtr: begin
				{en, rd} = {1'b1, ins[4:2]};
				for (int i = 0; i < 16; i++) begin
					data[i] = a[15 - i];
				end
			end
			opArith: begin
				{en, rd} = {1'b1, ins[4:2]};
				case (ins[1:0])
					2'd0: data = a + b;
					2'd1: data = b - a;
					2'd2: data = a ^ b;
					default: data = a & ~b;
				endcase
			end
			opShift: {en, rd, data} = {1'b1, ins[4:2], shiftOp(ins[1:0], a, b[3:0])};
			opSeq: {en, rd, data} = {1'b1, ins[4:2], 15'd0, a == b};
			opSlt: {en, rd, data} = {1'b1, ins[4:2], 15'd0, $signed(a) < $signed(b)};
			opSle: {en, rd, data} = {1'b1, ins[4:2], 15'd0, $signed(a) <= $signed(b)};
			opSco: {en, rd, data} = {1'b1, ins[4:2], 15'd0, wide[16]};
			opBeqz, opBnez, opBltz, opBgez: begin
				case (op)
					opBeqz: taken = (a == 16'd0);
					opBnez: taken = (a != 16'd0);
					opBltz: taken = a[15];
					default: taken = !a[15];
				endcase
				if (taken) begin
					nextPc = seqPc + s8;
				end
			end
			opJ: nextPc = seqPc + s11;
			opJal: begin
				nextPc = seqPc + s11;
				{en, rd, data} = {1'b1, 3'd7, seqPc};
			end
			opJr: nextPc = a + s8;
			opJalr: begin
				nextPc = a + s8;
				{en, rd, data} = {1'b1, 3'd7, seqPc};
			end
			default: en = 1'b0;
		endcase
	endfunction

	task automatic checkWord(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("error %s expected %h actual %h", name, exp, act);
			testErrors++;
		end
	endtask

	task automatic checkReg(input string name, input regAddr_t exp, input regAddr_t act);
		if (exp !== act) begin
			$display("error %s expected %h actual %h", name, exp, act);
			testErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("error %s expected %h actual %h", name, exp, act);
			testErrors++;
		end
	endtask

	// Compare the retiring instruction against the model
	always @(posedge clk) begin
		logic en;
		regAddr_t rd;
		word_t data;
		logic memEn;
		word_t addr;
		word_t stData;
		word_t nextPc;
		logic isHalt;
		if (checking && !done) begin
			checkWord("pc", refPc, pc);
			if (!refHalted) begin
				checkBit("halted", 1'b0, halted);
				refStep(instr, en, rd, data, memEn, addr, stData, nextPc, isHalt);
				checkBit("wbEnable", en, wbEnable);
				if (en) begin
					checkReg("wbReg", rd, wbReg);
					checkWord("wbData", data, wbData);
					refRegs[rd] = data;
				end
				checkBit("memWriteEn", memEn, memWriteEn);
				if (memEn) begin
					checkWord("memAddr", addr, memAddr);
					checkWord("memWriteData", stData, memWriteData);
					refMem[addr[8:1]] = stData;
				end
				refPc = nextPc;
				refHalted = isHalt;
			end else begin
				checkBit("halted", 1'b1, halted);
				checkBit("wbEnable", 1'b0, wbEnable);
				checkBit("memWriteEn", 1'b0, memWriteEn);
				postCount++;
				if (postCount >= postLimit) begin
					done = 1'b1;
				end
			end
		end
	end

	task automatic loadProgram(input int t);
		instr_t w;
		int r;
		for (int i = 0; i < 256; i++) begin
			imem[i] = {opNop, 11'd0};
		end
		for (int i = 0; i < progLen[t]; i++) begin
			w = progWords[progStart[t] + i];
			if (randomOps[t] && (w[15:11] == opLbi || w[15:11] == opSlbi)) begin
				r = $random(seed);
				w[7:0] = r[7:0];
			end
			imem[i] = w;
		end
	endtask

	task automatic runTest(input int t, input string label);
		int waited;
		int limit;
		loadProgram(t);
		testErrors = 0;
		postLimit = (t == numPrograms - 1) ? 10 : 2;
		limit = progLen[t] * 2 + postLimit + 10;
		@(negedge clk);
		reset = 1'b1;
		repeat (4) @(negedge clk);
		checkBit("halted", 1'b0, halted);
		checkWord("pc", 16'd0, pc);
		checkBit("wbEnable", 1'b0, wbEnable);
		checkBit("memWriteEn", 1'b0, memWriteEn);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < 8; i++) begin
			refRegs[i] = '0;
		end
		refPc = '0;
		refHalted = 1'b0;
		postCount = 0;
		done = 1'b0;
		checking = 1'b1;
		waited = 0;
		while (!done && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		checking = 1'b0;
		if (!done) begin
			$display("test %s: the program did not reach halt within %0d cycles", label, limit);
			testErrors++;
		end
		if (testErrors == 0) begin
			$display("test %s: ok", label);
			passCount++;
		end else begin
			$display("test %s: %0d errors", label, testErrors);
			failCount++;
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr = {opNop, 11'd0};
		seed = 64494;
		checking = 1'b0;
		done = 1'b0;
		refHalted = 1'b0;
		refPc = '0;
		postCount = 0;
		postLimit = 2;
		passCount = 0;
		failCount = 0;
		cycleCount = 0;
		runTest(0, "immediate");
		runTest(1, "register");
		runTest(2, "set");
		runTest(3, "memory");
		runTest(4, "control flow");
		runTest(5, "halt");
		// Second pass over the halt program after reset
		runTest(5, "halt restart");
		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+tb
design/wiscPkg.sv
design/fetchUnit.sv
design/control.sv
design/regFile.sv
design/execUnit.sv
design/memWriteback.sv
design/wiscCore.sv
tb/wiscCoreTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = wiscCoreTb
FILELIST = tb.f

BIN = obj_dir/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST)) tb/wiscPrograms.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
